//--- logic/udp_tx_pkg.sv
/*
 * Shared definitions for the UDP/PTP Ethernet transmitter.
 * Frame constants, fixed header fields, link credit depth, CRC-32 step.
 */
`default_nettype none

package udp_tx_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic {
        KIND_PTP = 1'b0,
        KIND_UDP = 1'b1
    } frame_kind_t;

    // Link flow control
    localparam int LINK_CREDITS = 4;
    localparam int CREDIT_W     = $clog2(LINK_CREDITS + 1);
    localparam int PTR_W        = $clog2(LINK_CREDITS);

    localparam int ETH_HDR_LEN      = 14;
    localparam int IP_HDR_LEN       = 20;
    localparam int UDP_HDR_LEN      = 8;
    localparam int UDP_FULL_HDR_LEN = ETH_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN;

    // GMII framing
    localparam int    MIN_FRAME_LEN = 60;
    localparam int    PREAMBLE_LEN  = 7;
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    IFG_CYCLES    = 12;

    localparam logic [47:0] LOCAL_MAC    = 48'h02_00_00_00_00_00;
    localparam logic [47:0] PTP_DEST_MAC = 48'h01_1B_19_00_00_00;
    localparam logic [47:0] UDP_DEST_MAC = 48'hFF_FF_FF_FF_FF_FF;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ETHERTYPE_PTP  = 16'h88F7;

    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [31:0] DEST_IP  = {8'd255, 8'd255, 8'd255, 8'd255};

    // IPv4 fixed fields, don't fragment set
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;
    localparam logic [7:0]  IP_TOS        = 8'h00;
    localparam logic [15:0] IP_ID         = 16'h0000;
    localparam logic [15:0] IP_FLAGS_FRAG = 16'h4000;
    localparam logic [7:0]  IP_TTL        = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    localparam logic [15:0] UDP_SRC_PORT  = 16'd1234;
    localparam logic [15:0] UDP_DEST_PORT = 16'd5555;

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // One byte of the reflected Ethernet CRC-32, LSB first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- logic/byte_link_if.sv
/*
 * Credit-controlled byte stream between two transmit stages.
 * Sender spends one credit per valid beat, receiver pulses credit per pop.
 */
`default_nettype none

interface byte_link_if
    import udp_tx_pkg::*;
();

    byte_t       data;
    logic        first;
    logic        last;
    logic        valid;
    // Frame attributes, meaningful with first
    frame_kind_t kind;
    logic [15:0] len;
    logic        credit;

    modport tx (
        output data, first, last, valid, kind, len,
        input  credit
    );

    modport rx (
        input  data, first, last, valid, kind, len,
        output credit
    );

endinterface

`default_nettype wire

//--- logic/frame_arbiter.sv
/*
 * Frame arbiter.
 * Round-robin choice of whole UDP or PTP frames, forwarded onto a
 * credit-controlled byte link one cycle after acceptance.
 */
`default_nettype none

module frame_arbiter
    import udp_tx_pkg::*;
(
    input  logic        logic_clk,
    input  logic        arst_n,

    input  byte_t       udp_data,
    input  logic        udp_valid,
    input  logic        udp_last,
    input  logic [15:0] udp_len,
    output logic        udp_ready,

    input  byte_t       ptp_data,
    input  logic        ptp_valid,
    input  logic        ptp_last,
    output logic        ptp_ready,

    byte_link_if.tx     out
);

    logic [CREDIT_W-1:0] credits;
    logic                busy;
    frame_kind_t         grant;
    frame_kind_t         cur_kind;
    logic                cur_valid;
    logic                cur_last;
    logic                take;

    // Grant holds inside a frame; on a tie the last served source yields
    always_comb begin
        if (busy) begin
            cur_kind = grant;
        end else if (udp_valid && ptp_valid) begin
            cur_kind = (grant == KIND_UDP) ? KIND_PTP : KIND_UDP;
        end else if (udp_valid) begin
            cur_kind = KIND_UDP;
        end else begin
            cur_kind = KIND_PTP;
        end
    end

    assign cur_valid = (cur_kind == KIND_UDP) ? udp_valid : ptp_valid;
    assign cur_last  = (cur_kind == KIND_UDP) ? udp_last : ptp_last;
    assign take      = cur_valid && (credits != '0);

    assign udp_ready = take && (cur_kind == KIND_UDP);
    assign ptp_ready = take && (cur_kind == KIND_PTP);

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            grant   <= KIND_PTP;
            credits <= CREDIT_W'(LINK_CREDITS);
        end else begin
            if (take) begin
                busy  <= !cur_last;
                grant <= cur_kind;
            end
            credits <= credits + CREDIT_W'(out.credit) - CREDIT_W'(take);
        end
    end

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= take;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (take) begin
            out.data  <= (cur_kind == KIND_UDP) ? udp_data : ptp_data;
            out.first <= !busy;
            out.last  <= cur_last;
            out.kind  <= cur_kind;
            out.len   <= (cur_kind == KIND_UDP) ? udp_len : 16'h0000;
        end
    end

endmodule

`default_nettype wire

//--- logic/header_inserter.sv
/*
 * Header inserter.
 * Buffers incoming beats, prepends the Ethernet header (plus IPv4 and UDP
 * headers with the IPv4 checksum for UDP frames), then passes the payload.
 */
`default_nettype none

module header_inserter
    import udp_tx_pkg::*;
(
    input  logic    logic_clk,
    input  logic    arst_n,
    byte_link_if.rx in,
    byte_link_if.tx out
);

    typedef struct packed {
        byte_t       data;
        logic        first;
        logic        last;
        frame_kind_t kind;
        logic [15:0] len;
    } beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } state_t;

    beat_t                         fifo_mem [LINK_CREDITS];
    beat_t                         head;
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [CREDIT_W-1:0]           count;
    logic [CREDIT_W-1:0]           out_credits;
    logic                          not_empty;
    logic                          can_send;
    logic                          send;
    logic                          pop;
    state_t                        state;
    logic [5:0]                    hdr_idx;
    logic [5:0]                    hdr_last_idx;
    frame_kind_t                   kind_q;
    frame_kind_t                   hdr_kind;
    logic [15:0]                   len_q;
    logic [15:0]                   hdr_len;
    logic [15:0]                   ip_len;
    logic [15:0]                   udp_length;
    logic [19:0]                   csum_sum;
    logic [16:0]                   csum_fold;
    logic [15:0]                   ip_csum;
    logic [UDP_FULL_HDR_LEN*8-1:0] hdr_vec;
    byte_t                         hdr_byte;

    assign head      = fifo_mem[rd_ptr];
    assign not_empty = (count != '0);
    assign can_send  = (out_credits != '0);

    // Header fields come from the head beat until they are latched
    assign hdr_kind     = (state == ST_IDLE) ? head.kind : kind_q;
    assign hdr_len      = (state == ST_IDLE) ? head.len : len_q;
    assign hdr_last_idx = (hdr_kind == KIND_UDP) ? 6'(UDP_FULL_HDR_LEN - 1)
                                                 : 6'(ETH_HDR_LEN - 1);

    assign ip_len     = hdr_len + 16'(IP_HDR_LEN + UDP_HDR_LEN);
    assign udp_length = hdr_len + 16'(UDP_HDR_LEN);

    // Ones' complement sum over the header words, checksum field as zero
    assign csum_sum  = {IP_VER_IHL, IP_TOS} + ip_len + IP_ID + IP_FLAGS_FRAG
                     + {IP_TTL, IP_PROTO_UDP} + LOCAL_IP[31:16] + LOCAL_IP[15:0]
                     + DEST_IP[31:16] + DEST_IP[15:0];
    assign csum_fold = csum_sum[15:0] + {13'h0, csum_sum[19:16]};
    assign ip_csum   = ~(csum_fold[15:0] + {15'h0, csum_fold[16]});

    // PTP frames use only the leading Ethernet part
    assign hdr_vec = {
        (hdr_kind == KIND_UDP) ? UDP_DEST_MAC : PTP_DEST_MAC,
        LOCAL_MAC,
        (hdr_kind == KIND_UDP) ? ETHERTYPE_IPV4 : ETHERTYPE_PTP,
        IP_VER_IHL, IP_TOS, ip_len, IP_ID, IP_FLAGS_FRAG,
        IP_TTL, IP_PROTO_UDP, ip_csum, LOCAL_IP, DEST_IP,
        UDP_SRC_PORT, UDP_DEST_PORT, udp_length, 16'h0000
    };

    assign hdr_byte = hdr_vec[8 * (UDP_FULL_HDR_LEN - 1 - int'(hdr_idx)) +: 8];

    always_comb begin
        send = 1'b0;
        pop  = 1'b0;
        case (state)
            ST_IDLE: send = not_empty && head.first && can_send;
            ST_HDR:  send = can_send;
            ST_DATA: begin
                send = not_empty && can_send;
                pop  = send;
            end
            default: send = 1'b0;
        endcase
    end

    always_ff @(posedge logic_clk) begin
        if (in.valid) begin
            fifo_mem[wr_ptr] <= '{data: in.data, first: in.first, last: in.last,
                                  kind: in.kind, len: in.len};
        end
    end

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_credits <= CREDIT_W'(LINK_CREDITS);
            in.credit   <= 1'b0;
            out.valid   <= 1'b0;
            state       <= ST_IDLE;
            hdr_idx     <= '0;
        end else begin
            wr_ptr      <= wr_ptr + PTR_W'(in.valid);
            rd_ptr      <= rd_ptr + PTR_W'(pop);
            count       <= count + CREDIT_W'(in.valid) - CREDIT_W'(pop);
            out_credits <= out_credits + CREDIT_W'(out.credit) - CREDIT_W'(send);
            in.credit   <= pop;
            out.valid   <= send;
            if (send) begin
                case (state)
                    ST_IDLE: begin
                        state   <= ST_HDR;
                        hdr_idx <= 6'd1;
                    end
                    ST_HDR: begin
                        if (hdr_idx == hdr_last_idx) begin
                            state   <= ST_DATA;
                            hdr_idx <= '0;
                        end else begin
                            hdr_idx <= hdr_idx + 6'd1;
                        end
                    end
                    default: begin
                        if (head.last) begin
                            state <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (send && state == ST_IDLE) begin
            kind_q <= head.kind;
            len_q  <= head.len;
        end
        if (send) begin
            out.data  <= (state == ST_DATA) ? head.data : hdr_byte;
            out.first <= (state == ST_IDLE);
            out.last  <= (state == ST_DATA) && head.last;
            out.kind  <= hdr_kind;
            out.len   <= hdr_len;
        end
    end

endmodule

`default_nettype wire

//--- logic/gmii_framer.sv
/*
 * GMII framer.
 * Sends each buffered frame with preamble and SFD, zero padding to the
 * minimum length, the FCS, and then holds the interframe gap.
 */
`default_nettype none

module gmii_framer
    import udp_tx_pkg::*;
(
    input  logic    logic_clk,
    input  logic    arst_n,
    byte_link_if.rx in,
    output byte_t   gmii_txd,
    output logic    gmii_tx_en,
    output logic    gmii_tx_er
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE,
        ST_DATA,
        ST_PAD,
        ST_FCS,
        ST_IFG
    } state_t;

    byte_t               data_mem [LINK_CREDITS];
    logic                last_mem [LINK_CREDITS];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic [CREDIT_W-1:0] last_cnt;
    byte_t               head_data;
    logic                head_last;
    logic                start;
    logic                pop;
    state_t              state;
    state_t              state_next;
    logic [15:0]         byte_cnt;
    logic [15:0]         cnt_next;
    logic                en_next;
    byte_t               txd_next;
    logic [31:0]         crc;
    logic [31:0]         crc_next;
    logic [31:0]         fcs;

    assign head_data = data_mem[rd_ptr];
    assign head_last = last_mem[rd_ptr];
    assign fcs       = ~crc;
    assign pop       = (state == ST_DATA);
    assign gmii_tx_er = 1'b0;

    // Full FIFO or a whole frame tail keeps the data phase gapless
    assign start = (state == ST_IDLE)
                && ((count == CREDIT_W'(LINK_CREDITS)) || (last_cnt != '0));

    always_comb begin
        state_next = state;
        cnt_next   = byte_cnt;
        en_next    = 1'b0;
        txd_next   = 8'h00;
        crc_next   = crc;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    en_next    = 1'b1;
                    txd_next   = PREAMBLE_BYTE;
                    cnt_next   = 16'd1;
                    state_next = ST_PRE;
                end
            end
            ST_PRE: begin
                en_next = 1'b1;
                if (byte_cnt == PREAMBLE_LEN) begin
                    txd_next   = SFD_BYTE;
                    cnt_next   = '0;
                    crc_next   = CRC_INIT;
                    state_next = ST_DATA;
                end else begin
                    txd_next = PREAMBLE_BYTE;
                    cnt_next = byte_cnt + 16'd1;
                end
            end
            ST_DATA: begin
                en_next  = 1'b1;
                txd_next = head_data;
                crc_next = crc32_step(crc, head_data);
                cnt_next = byte_cnt + 16'd1;
                if (head_last) begin
                    if (byte_cnt + 1 < MIN_FRAME_LEN) begin
                        state_next = ST_PAD;
                    end else begin
                        state_next = ST_FCS;
                        cnt_next   = '0;
                    end
                end
            end
            ST_PAD: begin
                en_next  = 1'b1;
                crc_next = crc32_step(crc, 8'h00);
                cnt_next = byte_cnt + 16'd1;
                if (byte_cnt + 1 == MIN_FRAME_LEN) begin
                    state_next = ST_FCS;
                    cnt_next   = '0;
                end
            end
            ST_FCS: begin
                en_next  = 1'b1;
                txd_next = fcs[8 * byte_cnt[1:0] +: 8];
                cnt_next = byte_cnt + 16'd1;
                if (byte_cnt == 16'd3) begin
                    state_next = ST_IFG;
                    cnt_next   = '0;
                end
            end
            default: begin
                cnt_next = byte_cnt + 16'd1;
                if (byte_cnt == IFG_CYCLES - 1) begin
                    state_next = ST_IDLE;
                    cnt_next   = '0;
                end
            end
        endcase
    end

    always_ff @(posedge logic_clk) begin
        if (in.valid) begin
            data_mem[wr_ptr] <= in.data;
            last_mem[wr_ptr] <= in.last;
        end
        gmii_txd <= txd_next;
        crc      <= crc_next;
    end

    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            last_cnt   <= '0;
            in.credit  <= 1'b0;
            state      <= ST_IDLE;
            byte_cnt   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr + PTR_W'(in.valid);
            rd_ptr     <= rd_ptr + PTR_W'(pop);
            count      <= count + CREDIT_W'(in.valid) - CREDIT_W'(pop);
            last_cnt   <= last_cnt + CREDIT_W'(in.valid && in.last)
                        - CREDIT_W'(pop && head_last);
            in.credit  <= pop;
            state      <= state_next;
            byte_cnt   <= cnt_next;
            gmii_tx_en <= en_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/udp_tx_top.sv
/*
 * UDP and PTP Ethernet transmitter top level.
 * Arbiter, header inserter and GMII framer joined by two credit links.
 */
`default_nettype none

module udp_tx_top
    import udp_tx_pkg::*;
(
    input  logic        logic_clk,
    input  logic        arst_n,

    input  byte_t       udp_data,
    input  logic        udp_valid,
    input  logic        udp_last,
    input  logic [15:0] udp_len,
    output logic        udp_ready,

    input  byte_t       ptp_data,
    input  logic        ptp_valid,
    input  logic        ptp_last,
    output logic        ptp_ready,

    output byte_t       gmii_txd,
    output logic        gmii_tx_en,
    output logic        gmii_tx_er
);

    byte_link_if arb_link ();
    byte_link_if hdr_link ();

    frame_arbiter u_arbiter (
        .logic_clk (logic_clk),
        .arst_n    (arst_n),
        .udp_data  (udp_data),
        .udp_valid (udp_valid),
        .udp_last  (udp_last),
        .udp_len   (udp_len),
        .udp_ready (udp_ready),
        .ptp_data  (ptp_data),
        .ptp_valid (ptp_valid),
        .ptp_last  (ptp_last),
        .ptp_ready (ptp_ready),
        .out       (arb_link.tx)
    );

    header_inserter u_inserter (
        .logic_clk (logic_clk),
        .arst_n    (arst_n),
        .in        (arb_link.rx),
        .out       (hdr_link.tx)
    );

    gmii_framer u_framer (
        .logic_clk  (logic_clk),
        .arst_n     (arst_n),
        .in         (hdr_link.rx),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/*
 * Testbench clock source, period of 4 time units.
 */
`default_nettype none

module tb_clock (
    output logic logic_clk
);

    initial begin
        logic_clk = 1'b0;
    end

    always #2 logic_clk = ~logic_clk;

endmodule

`default_nettype wire

//--- bench/udp_tx_chk.sv
/*
 * Bound port checks for the UDP/PTP transmitter.
 * Idle outputs in reset, unused GMII error line, interframe gap and
 * source ready held to one whole frame at a time.
 */
`default_nettype none

module udp_tx_chk
    import udp_tx_pkg::*;
(
    input logic logic_clk,
    input logic arst_n,
    input logic udp_valid,
    input logic udp_last,
    input logic udp_ready,
    input logic ptp_valid,
    input logic ptp_last,
    input logic ptp_ready,
    input logic gmii_tx_en,
    input logic gmii_tx_er
);

    int unsigned fail_count = 0;
    logic [4:0]  idle_cnt;
    logic        udp_open;
    logic        ptp_open;

    // Low cycles since the last frame, saturating
    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_cnt <= '1;
        end else if (gmii_tx_en) begin
            idle_cnt <= '0;
        end else if (idle_cnt != '1) begin
            idle_cnt <= idle_cnt + 5'd1;
        end
    end

    // Source part way through a frame
    always_ff @(posedge logic_clk or negedge arst_n) begin
        if (!arst_n) begin
            udp_open <= 1'b0;
            ptp_open <= 1'b0;
        end else begin
            if (udp_valid && udp_ready) begin
                udp_open <= !udp_last;
            end
            if (ptp_valid && ptp_ready) begin
                ptp_open <= !ptp_last;
            end
        end
    end

    reset_idle: assert property (@(posedge logic_clk)
        !arst_n |-> !gmii_tx_en && !udp_ready && !ptp_ready)
        else begin
            $error("GMII enable or a source ready is high during reset");
            fail_count++;
        end

    no_tx_error: assert property (@(posedge logic_clk) !gmii_tx_er)
        else begin
            $error("gmii_tx_er is high");
            fail_count++;
        end

    frame_gap: assert property (@(posedge logic_clk) disable iff (!arst_n)
        $rose(gmii_tx_en) |-> idle_cnt >= 5'(IFG_CYCLES))
        else begin
            $error("Frame started before the interframe gap ended");
            fail_count++;
        end

    one_ready: assert property (@(posedge logic_clk)
        !(udp_ready && ptp_ready) && !(udp_open && ptp_ready) && !(ptp_open && udp_ready))
        else begin
            $error("A source ready is high together with the other or inside its frame");
            fail_count++;
        end

endmodule

bind udp_tx_top udp_tx_chk u_chk (
    .logic_clk  (logic_clk),
    .arst_n     (arst_n),
    .udp_valid  (udp_valid),
    .udp_last   (udp_last),
    .udp_ready  (udp_ready),
    .ptp_valid  (ptp_valid),
    .ptp_last   (ptp_last),
    .ptp_ready  (ptp_ready),
    .gmii_tx_en (gmii_tx_en),
    .gmii_tx_er (gmii_tx_er)
);

`default_nettype wire

//--- bench/udp_tx_tb.sv
/*
 * Testbench for the UDP/PTP Ethernet transmitter.
 * Sends UDP and PTP frames, models each expected GMII frame with its
 * headers, padding and FCS, and compares it byte by byte.
 */
`default_nettype none

module udp_tx_tb
    import udp_tx_pkg::*;
();

    // Seven frames of at most about 230 wire cycles each, plus reset and slack
    localparam int CYCLE_LIMIT = 4000;

    logic        logic_clk;
    logic        arst_n;
    byte_t       udp_data;
    logic        udp_valid;
    logic        udp_last;
    logic [15:0] udp_len;
    logic        udp_ready;
    byte_t       ptp_data;
    logic        ptp_valid;
    logic        ptp_last;
    logic        ptp_ready;
    byte_t       gmii_txd;
    logic        gmii_tx_en;
    logic        gmii_tx_er;

    byte_t       model_buf[$];
    byte_t       exp_bytes[$];
    int          exp_lens[$];
    byte_t       rx_bytes[$];
    frame_kind_t accepted_kinds[$];
    int          frames_done;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          cycle_cnt;
    int          len_u0;
    int          len_u1;
    int          len_p0;
    int          len_p1;
    logic        alternates;

    tb_clock u_clock (
        .logic_clk (logic_clk)
    );

    udp_tx_top u_dut (
        .logic_clk  (logic_clk),
        .arst_n     (arst_n),
        .udp_data   (udp_data),
        .udp_valid  (udp_valid),
        .udp_last   (udp_last),
        .udp_len    (udp_len),
        .udp_ready  (udp_ready),
        .ptp_data   (ptp_data),
        .ptp_valid  (ptp_valid),
        .ptp_last   (ptp_last),
        .ptp_ready  (ptp_ready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    // Big-endian field into the model frame
    task automatic put_field(input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            model_buf.push_back(value[8 * i +: 8]);
        end
    endtask

    task automatic expect_frame(input frame_kind_t kind, input byte_t pl[$]);
        logic [31:0] sum;
        logic [31:0] crc;
        logic [15:0] csum;
        model_buf.delete();
        if (kind == KIND_UDP) begin
            put_field(UDP_DEST_MAC, 6);
            put_field(LOCAL_MAC, 6);
            put_field(ETHERTYPE_IPV4, 2);
            put_field(IP_VER_IHL, 1);
            put_field(IP_TOS, 1);
            put_field(48'(pl.size() + IP_HDR_LEN + UDP_HDR_LEN), 2);
            put_field(IP_ID, 2);
            put_field(IP_FLAGS_FRAG, 2);
            put_field(IP_TTL, 1);
            put_field(IP_PROTO_UDP, 1);
            put_field(48'h0, 2);
            put_field(LOCAL_IP, 4);
            put_field(DEST_IP, 4);
            put_field(UDP_SRC_PORT, 2);
            put_field(UDP_DEST_PORT, 2);
            put_field(48'(pl.size() + UDP_HDR_LEN), 2);
            put_field(48'h0, 2);
            // Ones' complement sum of the IPv4 header words
            sum = 32'h0;
            for (int i = 0; i < IP_HDR_LEN; i += 2) begin
                sum = sum + {16'h0, model_buf[ETH_HDR_LEN + i], model_buf[ETH_HDR_LEN + i + 1]};
            end
            while (sum[31:16] != 16'h0) begin
                sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
            end
            csum = ~sum[15:0];
            model_buf[ETH_HDR_LEN + 10] = csum[15:8];
            model_buf[ETH_HDR_LEN + 11] = csum[7:0];
        end else begin
            put_field(PTP_DEST_MAC, 6);
            put_field(LOCAL_MAC, 6);
            put_field(ETHERTYPE_PTP, 2);
        end
        foreach (pl[i]) begin
            model_buf.push_back(pl[i]);
        end
        while (model_buf.size() < MIN_FRAME_LEN) begin
            model_buf.push_back(8'h00);
        end
        repeat (PREAMBLE_LEN) exp_bytes.push_back(PREAMBLE_BYTE);
        exp_bytes.push_back(SFD_BYTE);
        crc = 32'hFFFF_FFFF;
        foreach (model_buf[i]) begin
            crc = crc32_step(crc, model_buf[i]);
            exp_bytes.push_back(model_buf[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(crc[8 * i +: 8]);
        end
        exp_lens.push_back(PREAMBLE_LEN + 1 + model_buf.size() + 4);
    endtask

    task automatic drive_beat(input frame_kind_t kind, input byte_t data, input logic last,
                              input logic [15:0] len);
        if (kind == KIND_UDP) begin
            udp_valid <= 1'b1;
            udp_data  <= data;
            udp_last  <= last;
            udp_len   <= len;
        end else begin
            ptp_valid <= 1'b1;
            ptp_data  <= data;
            ptp_last  <= last;
        end
    endtask

    task automatic release_source(input frame_kind_t kind);
        if (kind == KIND_UDP) begin
            udp_valid <= 1'b0;
            udp_last  <= 1'b0;
        end else begin
            ptp_valid <= 1'b0;
            ptp_last  <= 1'b0;
        end
    endtask

    // Valid stays high for the whole frame, bytes move on valid and ready
    task automatic send_frame(input frame_kind_t kind, input int len);
        byte_t pl[$];
        int    sent;
        logic  moved;
        for (int i = 0; i < len; i++) begin
            pl.push_back(byte_t'($urandom));
        end
        sent = 0;
        drive_beat(kind, pl[0], len == 1, 16'(len));
        while (sent < len) begin
            @(posedge logic_clk);
            moved = (kind == KIND_UDP) ? (udp_valid && udp_ready) : (ptp_valid && ptp_ready);
            if (moved) begin
                if (sent == 0) begin
                    expect_frame(kind, pl);
                    accepted_kinds.push_back(kind);
                end
                sent++;
                if (sent < len) begin
                    drive_beat(kind, pl[sent], sent == len - 1, 16'(len));
                end else begin
                    release_source(kind);
                end
            end
        end
    endtask

    task automatic check_frame();
        int    n;
        byte_t e;
        logic  bad;
        bad = 1'b0;
        assert (exp_lens.size() != 0) else begin
            $display("GMII output sent a frame of %0d bytes that no source started",
                     rx_bytes.size());
            errors++;
        end
        if (exp_lens.size() != 0) begin
            n = exp_lens.pop_front();
            assert (rx_bytes.size() == n) else begin
                $display("Error: gmii_tx_en frame length got 0x%0h expected 0x%0h",
                         rx_bytes.size(), n);
                errors++;
            end
            for (int i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                if (!bad && i < rx_bytes.size()) begin
                    assert (rx_bytes[i] == e) else begin
                        $display("Error: gmii_txd byte %0d got 0x%02h expected 0x%02h",
                                 i, rx_bytes[i], e);
                        errors++;
                        bad = 1'b1;
                    end
                end
            end
        end
        frames_done++;
    endtask

    task automatic wait_frames(input int target);
        while (frames_done < target) begin
            @(posedge logic_clk);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: finished, %0d errors", name, errors - err_mark);
        tests_run++;
        err_mark = errors;
    endtask

    // Frame ends when the enable drops
    always @(posedge logic_clk) begin
        if (gmii_tx_en) begin
            rx_bytes.push_back(gmii_txd);
        end else if (rx_bytes.size() != 0) begin
            check_frame();
            rx_bytes.delete();
        end
    end

    always @(posedge logic_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d with %0d frames checked",
                     CYCLE_LIMIT, frames_done);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h8ee82481));
        arst_n      = 1'b0;
        udp_data    = 8'h00;
        udp_valid   = 1'b0;
        udp_last    = 1'b0;
        udp_len     = 16'h0000;
        ptp_data    = 8'h00;
        ptp_valid   = 1'b0;
        ptp_last    = 1'b0;
        frames_done = 0;
        errors      = 0;
        err_mark    = 0;
        tests_run   = 0;
        cycle_cnt   = 0;
        repeat (16) @(posedge logic_clk);
        arst_n <= 1'b1;
        @(posedge logic_clk);

        send_frame(KIND_UDP, 100);
        wait_frames(1);
        finish_test("udp_payload_100");

        send_frame(KIND_PTP, 20 + int'($urandom % 100));
        wait_frames(2);
        finish_test("ptp_payload");

        send_frame(KIND_UDP, 5);
        wait_frames(3);
        finish_test("udp_short_padded");

        // Both sources pending for the whole test
        len_u0 = 1 + int'($urandom % 150);
        len_u1 = 1 + int'($urandom % 150);
        len_p0 = 1 + int'($urandom % 180);
        len_p1 = 1 + int'($urandom % 180);
        accepted_kinds.delete();
        fork
            begin
                send_frame(KIND_UDP, len_u0);
                send_frame(KIND_UDP, len_u1);
            end
            begin
                send_frame(KIND_PTP, len_p0);
                send_frame(KIND_PTP, len_p1);
            end
        join
        wait_frames(7);
        alternates = 1'b1;
        for (int i = 1; i < accepted_kinds.size(); i++) begin
            if (accepted_kinds[i] == accepted_kinds[i - 1]) begin
                alternates = 1'b0;
            end
        end
        assert (alternates) else begin
            $display("Frames from the two pending sources did not alternate");
            errors++;
        end
        finish_test("round_robin_both_pending");

        assert (exp_lens.size() == 0) else begin
            $display("%0d expected frames never appeared on the GMII output", exp_lens.size());
            errors++;
        end
        $display("%0d tests, %0d frames, %0d check errors, %0d assertion failures",
                 tests_run, frames_done, errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/udp_tx_pkg.sv
logic/byte_link_if.sv
logic/frame_arbiter.sv
logic/header_inserter.sv
logic/gmii_framer.sv
logic/udp_tx_top.sv
bench/tb_clock.sv
bench/udp_tx_chk.sv
bench/udp_tx_tb.sv

//--- Makefile
TOP := udp_tx_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): vlog.f $(wildcard logic/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	! grep -q "Test failed" sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
